/* common/per2axi_defines.svh */
// Width settings for the peripheral-to-AXI bridge
// Shared by both type packages, the busy unit and the testbench

`ifndef PER2AXI_DEFINES_SVH
`define PER2AXI_DEFINES_SVH

// Number of peripheral requesters, also the one-hot ID width
`define PER2AXI_PER_ID_WIDTH 5

// Binary AXI ID, must cover the requester count
`define PER2AXI_AXI_ID_WIDTH 3

// Byte address on both sides
`define PER2AXI_AXI_ADDR_WIDTH 32

// AXI data bus, two 32-bit lanes
`define PER2AXI_AXI_DATA_WIDTH 64

// Outstanding-transaction counter
`define PER2AXI_BUSY_CNT_WIDTH 4

`endif

/* common/per_pkg.sv */
// Peripheral interconnect types
// Requester ID, address, data and byte enables of the req/gnt bus

`default_nettype none

`include "per2axi_defines.svh"

package per_pkg;

   // ************************************************************
   // Request side
   // ************************************************************

   // One-hot requester ID, one bit per master port
   typedef logic [`PER2AXI_PER_ID_WIDTH-1:0] per_id_t;

   // Byte address as issued by the master
   typedef logic [31:0] per_addr_t;

   // Single 32-bit word, write data and read data alike
   typedef logic [31:0] per_data_t;

   // One enable per byte of the word
   typedef logic [3:0] per_be_t;

   // ************************************************************
   // Response side
   // ************************************************************
   // The response reuses per_id_t for the returned one-hot ID
   // and per_data_t for the read data; opc is a single flag,
   // high when the slave reported an error

endpackage

`default_nettype wire

/* common/axi_pkg.sv */
// AXI4 master side types
// Binary ID, address, strobes, response codes and the 64-bit data word
// with its raw and per-lane views

`default_nettype none

`include "per2axi_defines.svh"

package axi_pkg;

   // Binary transaction ID, one value per requester
   typedef logic [`PER2AXI_AXI_ID_WIDTH-1:0] axi_id_t;

   // Byte address on AW and AR
   typedef logic [`PER2AXI_AXI_ADDR_WIDTH-1:0] axi_addr_t;

   // One strobe per byte of the data bus
   typedef logic [`PER2AXI_AXI_DATA_WIDTH/8-1:0] axi_strb_t;

   // Response code on R and B
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   // ************************************************************
   // Data word
   // ************************************************************

   // Two 32-bit lanes, hi holds bytes 7..4
   typedef struct packed {
      logic [`PER2AXI_AXI_DATA_WIDTH/2-1:0] hi;
      logic [`PER2AXI_AXI_DATA_WIDTH/2-1:0] lo;
   } axi_lanes_t;

   // Raw view as it travels on the bus
   // Lane view for steering writes and picking read data
   typedef union packed {
      logic [`PER2AXI_AXI_DATA_WIDTH-1:0] raw;
      axi_lanes_t                         lanes;
   } axi_data_u;

endpackage

`default_nettype wire

/* common/per2axi_trans_if.sv */
// Granted-transaction record
// Published by the request channel in the cycle of each grant,
// read by the response channel and the busy unit

`timescale 1ns/1ps
`default_nettype none

interface per2axi_trans_if;

   import axi_pkg::*;

   // High for exactly the grant cycle
   logic      trans_req;
   // Binary ID of the granted requester
   axi_id_t   trans_id;
   // Request address, bit 2 picks the data lane
   axi_addr_t trans_add;
   // High for a write, low for a read
   logic      trans_we;

   // Request channel side
   modport master (output trans_req, output trans_id, output trans_add, output trans_we);

   // Response channel and busy unit side
   modport slave (input trans_req, input trans_id, input trans_add, input trans_we);

endinterface

`default_nettype wire

/* source/per2axi_req_channel.sv */
// Request channel of the bridge
// Turns each peripheral request into an AR beat or an AW/W pair,
// encodes the one-hot ID and steers write data into its 32-bit lane

`timescale 1ns/1ps
`default_nettype none

`include "per2axi_defines.svh"

module per2axi_req_channel
(
   // Peripheral request
   input  wire logic                per_slave_req_i,
   input  wire per_pkg::per_addr_t  per_slave_add_i,
   input  wire logic                per_slave_we_i,
   input  wire per_pkg::per_be_t    per_slave_be_i,
   input  wire per_pkg::per_data_t  per_slave_wdata_i,
   input  wire per_pkg::per_id_t    per_slave_id_i,
   output logic                     per_slave_gnt_o,

   // AXI write address
   output logic                     axi_aw_valid_o,
   output axi_pkg::axi_addr_t       axi_aw_addr_o,
   output axi_pkg::axi_id_t         axi_aw_id_o,
   input  wire logic                axi_aw_ready_i,
   // AXI write data
   output logic                     axi_w_valid_o,
   output axi_pkg::axi_data_u       axi_w_data_o,
   output axi_pkg::axi_strb_t       axi_w_strb_o,
   input  wire logic                axi_w_ready_i,
   // AXI read address
   output logic                     axi_ar_valid_o,
   output axi_pkg::axi_addr_t       axi_ar_addr_o,
   output axi_pkg::axi_id_t         axi_ar_id_o,
   input  wire logic                axi_ar_ready_i,

   // Granted-transaction record
   per2axi_trans_if.master          trans
);

   import axi_pkg::*;

   axi_id_t axi_id;

   // ************************************************************
   // ID encoding
   // ************************************************************
   // One-hot to binary, OR of the indices of the set bits
   always_comb
   begin
      axi_id = '0;
      for (int unsigned i = 0; i < `PER2AXI_PER_ID_WIDTH; i++)
      begin
         if (per_slave_id_i[i])
         begin
            axi_id = axi_id | axi_id_t'(i);
         end
      end
   end

   // ************************************************************
   // Address channels
   // ************************************************************
   // Valids only follow req and we, never ready
   assign axi_ar_valid_o = per_slave_req_i & ~per_slave_we_i;
   assign axi_aw_valid_o = per_slave_req_i & per_slave_we_i;
   assign axi_w_valid_o  = per_slave_req_i & per_slave_we_i;

   // Same address and ID on both address channels
   assign axi_ar_addr_o = per_slave_add_i;
   assign axi_aw_addr_o = per_slave_add_i;
   assign axi_ar_id_o   = axi_id;
   assign axi_aw_id_o   = axi_id;

   // Write lane steering, address bit 2 picks the upper lane
   always_comb
   begin
      axi_w_data_o = '0;
      if (per_slave_add_i[2])
      begin
         axi_w_data_o.lanes.hi = per_slave_wdata_i;
         axi_w_strb_o          = {per_slave_be_i, 4'b0000};
      end
      else
      begin
         axi_w_data_o.lanes.lo = per_slave_wdata_i;
         axi_w_strb_o          = {4'b0000, per_slave_be_i};
      end
   end

   // Grant follows ready; a write needs AW and W accepted together
   assign per_slave_gnt_o = per_slave_we_i ? (axi_aw_ready_i & axi_w_ready_i) : axi_ar_ready_i;

   // Publish every granted request
   assign trans.trans_req = per_slave_req_i & per_slave_gnt_o;
   assign trans.trans_id  = axi_id;
   assign trans.trans_add = per_slave_add_i;
   assign trans.trans_we  = per_slave_we_i;

endmodule

`default_nettype wire

/* source/per2axi_res_channel.sv */
// Response channel of the bridge
// Merges R and B into the peripheral response, R first, and picks
// the read lane recorded when the read was granted

`timescale 1ns/1ps
`default_nettype none

`include "per2axi_defines.svh"

module per2axi_res_channel
(
   input  wire logic                clk_i,
   input  wire logic                rst_ni,

   // Peripheral response
   output logic                     per_slave_r_valid_o,
   output logic                     per_slave_r_opc_o,
   output per_pkg::per_id_t         per_slave_r_id_o,
   output per_pkg::per_data_t       per_slave_r_rdata_o,

   // AXI read data
   input  wire logic                axi_r_valid_i,
   input  wire axi_pkg::axi_data_u  axi_r_data_i,
   input  wire axi_pkg::axi_resp_e  axi_r_resp_i,
   input  wire axi_pkg::axi_id_t    axi_r_id_i,
   output logic                     axi_r_ready_o,
   // AXI write response
   input  wire logic                axi_b_valid_i,
   input  wire axi_pkg::axi_resp_e  axi_b_resp_i,
   input  wire axi_pkg::axi_id_t    axi_b_id_i,
   output logic                     axi_b_ready_o,

   // Granted-transaction record
   per2axi_trans_if.slave           trans
);

   import per_pkg::*;
   import axi_pkg::*;

   // One lane bit per AXI ID
   logic [(1 << `PER2AXI_AXI_ID_WIDTH)-1:0] lane_sel_q;
   per_data_t                               r_lane;

   // ************************************************************
   // Lane buffer
   // ************************************************************
   // Written at the edge that ends a granted read
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         lane_sel_q <= '0;
      end
      else if (trans.trans_req && !trans.trans_we)
      begin
         lane_sel_q[trans.trans_id] <= trans.trans_add[2];
      end
   end

   // Upper or lower 32 bits of the R beat
   assign r_lane = lane_sel_q[axi_r_id_i] ? axi_r_data_i.lanes.hi : axi_r_data_i.lanes.lo;

   // Reads are always accepted
   assign axi_r_ready_o = 1'b1;

   // ************************************************************
   // Response merging
   // ************************************************************
   always_comb
   begin
      per_slave_r_valid_o = 1'b0;
      per_slave_r_opc_o   = 1'b0;
      per_slave_r_id_o    = '0;
      per_slave_r_rdata_o = '0;
      axi_b_ready_o       = 1'b1;
      if (axi_r_valid_i)
      begin
         // R wins, B stays pending for a later cycle
         per_slave_r_valid_o = 1'b1;
         per_slave_r_opc_o   = (axi_r_resp_i == SLVERR) || (axi_r_resp_i == DECERR);
         per_slave_r_id_o    = per_id_t'(1) << axi_r_id_i;
         per_slave_r_rdata_o = r_lane;
         axi_b_ready_o       = 1'b0;
      end
      else if (axi_b_valid_i)
      begin
         per_slave_r_valid_o = 1'b1;
         per_slave_r_opc_o   = (axi_b_resp_i == SLVERR) || (axi_b_resp_i == DECERR);
         per_slave_r_id_o    = per_id_t'(1) << axi_b_id_i;
      end
   end

endmodule

`default_nettype wire

/* source/per2axi_busy_unit.sv */
// Busy unit of the bridge
// Counts granted transactions against forwarded responses and flags
// the bridge busy while any remain outstanding

`timescale 1ns/1ps
`default_nettype none

`include "per2axi_defines.svh"

module per2axi_busy_unit
(
   input  wire logic       clk_i,
   input  wire logic       rst_ni,

   // Granted-transaction record
   per2axi_trans_if.slave  trans,

   // One pulse per forwarded response
   input  wire logic       per_slave_r_valid_i,

   output logic            busy_o
);

   logic [`PER2AXI_BUSY_CNT_WIDTH-1:0] cnt_q;
   logic [`PER2AXI_BUSY_CNT_WIDTH-1:0] cnt_d;

   // Grant and response in one cycle cancel out
   always_comb
   begin
      case ({trans.trans_req, per_slave_r_valid_i})
         2'b10:   cnt_d = cnt_q + 1'b1;
         2'b01:   cnt_d = cnt_q - 1'b1;
         default: cnt_d = cnt_q;
      endcase
   end

   // busy follows the next count, one cycle after grant or last response
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         cnt_q  <= '0;
         busy_o <= 1'b0;
      end
      else
      begin
         cnt_q  <= cnt_d;
         busy_o <= (cnt_d != '0);
      end
   end

endmodule

`default_nettype wire

/* source/per2axi.sv */
// Peripheral interconnect to AXI4 master bridge
// Single 32-bit requests become single-beat AXI transactions on a
// 64-bit bus; R and B beats come back as one-hot responses

`timescale 1ns/1ps
`default_nettype none

module per2axi
(
   input  wire logic                clk_i,
   input  wire logic                rst_ni,

   // ************************************************************
   // Peripheral interconnect slave
   // ************************************************************
   // Request
   input  wire logic                per_slave_req_i,
   input  wire per_pkg::per_addr_t  per_slave_add_i,
   input  wire logic                per_slave_we_i,
   input  wire per_pkg::per_be_t    per_slave_be_i,
   input  wire per_pkg::per_data_t  per_slave_wdata_i,
   input  wire per_pkg::per_id_t    per_slave_id_i,
   output logic                     per_slave_gnt_o,
   // Response
   output logic                     per_slave_r_valid_o,
   output logic                     per_slave_r_opc_o,
   output per_pkg::per_id_t         per_slave_r_id_o,
   output per_pkg::per_data_t       per_slave_r_rdata_o,

   // ************************************************************
   // AXI4 master
   // ************************************************************
   // Write address
   output logic                     axi_aw_valid_o,
   output axi_pkg::axi_addr_t       axi_aw_addr_o,
   output axi_pkg::axi_id_t         axi_aw_id_o,
   input  wire logic                axi_aw_ready_i,
   // Write data
   output logic                     axi_w_valid_o,
   output axi_pkg::axi_data_u       axi_w_data_o,
   output axi_pkg::axi_strb_t       axi_w_strb_o,
   input  wire logic                axi_w_ready_i,
   // Read address
   output logic                     axi_ar_valid_o,
   output axi_pkg::axi_addr_t       axi_ar_addr_o,
   output axi_pkg::axi_id_t         axi_ar_id_o,
   input  wire logic                axi_ar_ready_i,
   // Read data
   input  wire logic                axi_r_valid_i,
   input  wire axi_pkg::axi_data_u  axi_r_data_i,
   input  wire axi_pkg::axi_resp_e  axi_r_resp_i,
   input  wire axi_pkg::axi_id_t    axi_r_id_i,
   output logic                     axi_r_ready_o,
   // Write response
   input  wire logic                axi_b_valid_i,
   input  wire axi_pkg::axi_resp_e  axi_b_resp_i,
   input  wire axi_pkg::axi_id_t    axi_b_id_i,
   output logic                     axi_b_ready_o,

   // High while any transaction is outstanding
   output logic                     busy_o
);

   // Granted-transaction record shared by the three blocks
   per2axi_trans_if trans ();

   // Request translation, drives the record
   per2axi_req_channel req_channel_i (
      .per_slave_req_i   (per_slave_req_i),
      .per_slave_add_i   (per_slave_add_i),
      .per_slave_we_i    (per_slave_we_i),
      .per_slave_be_i    (per_slave_be_i),
      .per_slave_wdata_i (per_slave_wdata_i),
      .per_slave_id_i    (per_slave_id_i),
      .per_slave_gnt_o   (per_slave_gnt_o),
      .axi_aw_valid_o    (axi_aw_valid_o),
      .axi_aw_addr_o     (axi_aw_addr_o),
      .axi_aw_id_o       (axi_aw_id_o),
      .axi_aw_ready_i    (axi_aw_ready_i),
      .axi_w_valid_o     (axi_w_valid_o),
      .axi_w_data_o      (axi_w_data_o),
      .axi_w_strb_o      (axi_w_strb_o),
      .axi_w_ready_i     (axi_w_ready_i),
      .axi_ar_valid_o    (axi_ar_valid_o),
      .axi_ar_addr_o     (axi_ar_addr_o),
      .axi_ar_id_o       (axi_ar_id_o),
      .axi_ar_ready_i    (axi_ar_ready_i),
      .trans             (trans.master)
   );

   // Response merging and read-lane selection
   per2axi_res_channel res_channel_i (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .per_slave_r_valid_o (per_slave_r_valid_o),
      .per_slave_r_opc_o   (per_slave_r_opc_o),
      .per_slave_r_id_o    (per_slave_r_id_o),
      .per_slave_r_rdata_o (per_slave_r_rdata_o),
      .axi_r_valid_i       (axi_r_valid_i),
      .axi_r_data_i        (axi_r_data_i),
      .axi_r_resp_i        (axi_r_resp_i),
      .axi_r_id_i          (axi_r_id_i),
      .axi_r_ready_o       (axi_r_ready_o),
      .axi_b_valid_i       (axi_b_valid_i),
      .axi_b_resp_i        (axi_b_resp_i),
      .axi_b_id_i          (axi_b_id_i),
      .axi_b_ready_o       (axi_b_ready_o),
      .trans               (trans.slave)
   );

   // Outstanding-transaction tracking
   per2axi_busy_unit busy_unit_i (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .trans               (trans.slave),
      .per_slave_r_valid_i (per_slave_r_valid_o),
      .busy_o              (busy_o)
   );

endmodule

`default_nettype wire

/* sim/axi_mem_model.sv */
// Behavioural AXI4 slave for the bridge testbench
// Byte-strobed 64-bit memory, responses at least two cycles after each
// beat, random ready and response stalls, SLVERR in a fixed window

`timescale 1ns/1ps
`default_nettype none

module axi_mem_model
(
   input  wire logic                clk_i,
   input  wire logic                rst_ni,
   // Write address and data
   input  wire logic                aw_valid_i,
   input  wire axi_pkg::axi_addr_t  aw_addr_i,
   input  wire axi_pkg::axi_id_t    aw_id_i,
   output logic                     aw_ready_o,
   input  wire logic                w_valid_i,
   input  wire axi_pkg::axi_data_u  w_data_i,
   input  wire axi_pkg::axi_strb_t  w_strb_i,
   output logic                     w_ready_o,
   // Read address
   input  wire logic                ar_valid_i,
   input  wire axi_pkg::axi_addr_t  ar_addr_i,
   input  wire axi_pkg::axi_id_t    ar_id_i,
   output logic                     ar_ready_o,
   // Read data and write response
   output logic                     r_valid_o,
   output axi_pkg::axi_data_u       r_data_o,
   output axi_pkg::axi_resp_e       r_resp_o,
   output axi_pkg::axi_id_t         r_id_o,
   input  wire logic                r_ready_i,
   output logic                     b_valid_o,
   output axi_pkg::axi_resp_e       b_resp_o,
   output axi_pkg::axi_id_t         b_id_o,
   input  wire logic                b_ready_i
);

   import axi_pkg::*;

   localparam int unsigned LATENCY = 2;

   // Queued response, due is the earliest edge that may present it
   typedef struct packed {
      logic [31:0] due;
      axi_id_t     id;
      axi_resp_e   resp;
      axi_data_u   data;
   } rsp_t;

   logic [63:0] mem [64];
   rsp_t        r_q[$];
   rsp_t        b_q[$];
   logic [31:0] cycle;

   // Word pattern for a byte address
   function automatic logic [31:0] fill_word(input logic [31:0] a);
      return {~a[15:0], a[15:0]};
   endfunction

   // SLVERR window 0x100 to 0x1ff
   function automatic logic in_err_window(input axi_addr_t a);
      return (a >= 32'h100) && (a < 32'h200);
   endfunction

   initial
   begin
      for (int unsigned i = 0; i < 64; i++)
      begin
         mem[i] = {fill_word(i * 8 + 4), fill_word(i * 8)};
      end
   end

   // ************************************************************
   // Beat acceptance and response scheduling
   // ************************************************************
   always @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         aw_ready_o <= 1'b0;
         w_ready_o  <= 1'b0;
         ar_ready_o <= 1'b0;
         r_valid_o  <= 1'b0;
         r_data_o   <= '0;
         r_resp_o   <= OKAY;
         r_id_o     <= '0;
         b_valid_o  <= 1'b0;
         b_resp_o   <= OKAY;
         b_id_o     <= '0;
         r_q.delete();
         b_q.delete();
         cycle = '0;
      end
      else
      begin
         cycle = cycle + 1;
         // Beats taken by the bridge at this edge
         if (r_valid_o && r_ready_i)
         begin
            void'(r_q.pop_front());
         end
         if (b_valid_o && b_ready_i)
         begin
            void'(b_q.pop_front());
         end
         // Read captures the word at acceptance, error reads return zero
         if (ar_valid_i && ar_ready_o)
         begin
            r_q.push_back({cycle + LATENCY, ar_id_i,
                           in_err_window(ar_addr_i) ? SLVERR : OKAY,
                           in_err_window(ar_addr_i) ? 64'h0 : mem[ar_addr_i[8:3]]});
         end
         // AW and W always complete together
         if (aw_valid_i && aw_ready_o && w_valid_i && w_ready_o)
         begin
            if (!in_err_window(aw_addr_i))
            begin
               for (int unsigned b = 0; b < 8; b++)
               begin
                  if (w_strb_i[b])
                  begin
                     mem[aw_addr_i[8:3]][8*b +: 8] = w_data_i.raw[8*b +: 8];
                  end
               end
            end
            b_q.push_back({cycle + LATENCY, aw_id_i,
                           in_err_window(aw_addr_i) ? SLVERR : OKAY, 64'h0});
         end
         // Random ready stalls on the request side
         aw_ready_o <= ($urandom % 4) != 0;
         w_ready_o  <= ($urandom % 4) != 0;
         ar_ready_o <= ($urandom % 4) != 0;
         // Present a due head, held until its handshake
         if (!(r_valid_o && !r_ready_i))
         begin
            r_valid_o <= 1'b0;
            if (r_q.size() != 0)
            begin
               if (r_q[0].due <= cycle && ($urandom % 2) != 0)
               begin
                  r_valid_o <= 1'b1;
                  r_data_o  <= r_q[0].data;
                  r_resp_o  <= r_q[0].resp;
                  r_id_o    <= r_q[0].id;
               end
            end
         end
         if (!(b_valid_o && !b_ready_i))
         begin
            b_valid_o <= 1'b0;
            if (b_q.size() != 0)
            begin
               if (b_q[0].due <= cycle && ($urandom % 2) != 0)
               begin
                  b_valid_o <= 1'b1;
                  b_resp_o  <= b_q[0].resp;
                  b_id_o    <= b_q[0].id;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* sim/tb_per2axi.sv */
// Testbench for the peripheral-to-AXI bridge
// Table of writes and reads applied in a loop against a behavioural
// AXI slave, expected read data from a golden word array

`timescale 1ns/1ps
`default_nettype none

`include "per2axi_defines.svh"

module tb_per2axi;

   import per_pkg::*;
   import axi_pkg::*;

   localparam int unsigned N_ID           = `PER2AXI_PER_ID_WIDTH;
   localparam int unsigned RESET_CYCLES   = 16;
   localparam int unsigned CYCLES_PER_ROW = 20;

   // One table row
   // Low wait_rsp lets the next row start at once
   typedef struct packed {
      logic      we;
      logic      wait_rsp;
      per_id_t   id;
      per_addr_t addr;
      per_data_t wdata;
      per_be_t   be;
      per_data_t exp_rdata;
      logic      exp_opc;
   } row_t;

   logic      clk_i;
   logic      rst_ni;
   logic      per_req;
   per_addr_t per_add;
   logic      per_we;
   per_be_t   per_be;
   per_data_t per_wdata;
   per_id_t   per_id;
   logic      per_gnt;
   logic      per_r_valid;
   logic      per_r_opc;
   per_id_t   per_r_id;
   per_data_t per_r_rdata;
   logic      aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
   axi_addr_t aw_addr, ar_addr;
   axi_id_t   aw_id, ar_id, r_id, b_id;
   axi_data_u w_data, r_data;
   axi_strb_t w_strb;
   logic      r_valid, r_ready, b_valid, b_ready;
   axi_resp_e r_resp, b_resp;
   logic      busy;

   row_t        row_q[$];
   per_data_t   golden [128];
   row_t        pend_row [N_ID];
   logic        pend_valid [N_ID];
   int unsigned mon_idx;
   int unsigned cycle_cnt = 0;
   int unsigned timeout_limit = 0;
   int unsigned coincide_cnt = 0;

   per2axi dut_i (
      .clk_i (clk_i), .rst_ni (rst_ni),
      .per_slave_req_i (per_req), .per_slave_add_i (per_add), .per_slave_we_i (per_we),
      .per_slave_be_i (per_be), .per_slave_wdata_i (per_wdata), .per_slave_id_i (per_id),
      .per_slave_gnt_o (per_gnt),
      .per_slave_r_valid_o (per_r_valid), .per_slave_r_opc_o (per_r_opc),
      .per_slave_r_id_o (per_r_id), .per_slave_r_rdata_o (per_r_rdata),
      .axi_aw_valid_o (aw_valid), .axi_aw_addr_o (aw_addr), .axi_aw_id_o (aw_id),
      .axi_aw_ready_i (aw_ready),
      .axi_w_valid_o (w_valid), .axi_w_data_o (w_data), .axi_w_strb_o (w_strb),
      .axi_w_ready_i (w_ready),
      .axi_ar_valid_o (ar_valid), .axi_ar_addr_o (ar_addr), .axi_ar_id_o (ar_id),
      .axi_ar_ready_i (ar_ready),
      .axi_r_valid_i (r_valid), .axi_r_data_i (r_data), .axi_r_resp_i (r_resp),
      .axi_r_id_i (r_id), .axi_r_ready_o (r_ready),
      .axi_b_valid_i (b_valid), .axi_b_resp_i (b_resp), .axi_b_id_i (b_id),
      .axi_b_ready_o (b_ready),
      .busy_o (busy)
   );

   axi_mem_model mem_i (
      .clk_i (clk_i), .rst_ni (rst_ni),
      .aw_valid_i (aw_valid), .aw_addr_i (aw_addr), .aw_id_i (aw_id), .aw_ready_o (aw_ready),
      .w_valid_i (w_valid), .w_data_i (w_data), .w_strb_i (w_strb), .w_ready_o (w_ready),
      .ar_valid_i (ar_valid), .ar_addr_i (ar_addr), .ar_id_i (ar_id), .ar_ready_o (ar_ready),
      .r_valid_o (r_valid), .r_data_o (r_data), .r_resp_o (r_resp), .r_id_o (r_id),
      .r_ready_i (r_ready),
      .b_valid_o (b_valid), .b_resp_o (b_resp), .b_id_o (b_id), .b_ready_i (b_ready)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // ************************************************************
   // Reference rules and checks
   // ************************************************************
   // Initial word at a byte address
   // Same pattern as the slave memory
   function automatic per_data_t fill_word(input logic [31:0] a);
      return {~a[15:0], a[15:0]};
   endfunction

   // Slave answers SLVERR from 0x100 to 0x1ff
   function automatic logic in_err_window(input per_addr_t a);
      return (a >= 32'h100) && (a < 32'h200);
   endfunction

   // Lowest set bit or N_ID when none
   function automatic int unsigned first_set(input per_id_t v);
      int unsigned n;
      n = N_ID;
      for (int unsigned i = N_ID; i > 0; i--)
      begin
         if (v[i-1])
         begin
            n = i - 1;
         end
      end
      return n;
   endfunction

   function automatic int unsigned pending_count();
      int unsigned n;
      n = 0;
      for (int unsigned i = 0; i < N_ID; i++)
      begin
         n = n + pend_valid[i];
      end
      return n;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run aborted");
   endtask

   task automatic check_data(input per_data_t act, input per_data_t exp, input string what);
      if (act !== exp)
      begin
         abort_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, what, act, exp));
      end
   endtask

   task automatic check_id(input per_id_t act, input per_id_t exp, input string what);
      if (act !== exp)
      begin
         abort_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, what, act, exp));
      end
   endtask

   task automatic check_flag(input logic act, input logic exp, input string what);
      if (act !== exp)
      begin
         abort_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, what, act, exp));
      end
   endtask

   // Row with expectations from the golden array
   // Writes merge per byte into the golden word
   task automatic add_row(input logic we, input logic wait_rsp, input per_id_t id,
                          input per_addr_t addr, input per_data_t wdata, input per_be_t be);
      row_t r;
      r = {we, wait_rsp, id, addr, wdata, be, 32'h0, in_err_window(addr)};
      if (we && !r.exp_opc)
      begin
         for (int unsigned b = 0; b < 4; b++)
         begin
            if (be[b])
            begin
               golden[addr[8:2]][8*b +: 8] = wdata[8*b +: 8];
            end
         end
      end
      else if (!we)
      begin
         r.exp_rdata = golden[addr[8:2]];
      end
      row_q.push_back(r);
   endtask

   // ************************************************************
   // Request driving and response tracking
   // ************************************************************
   // Entered 2 ns after an edge and left there with req low
   task automatic issue(input row_t r);
      int unsigned idx;
      idx = first_set(r.id);
      per_req   = 1'b1;
      per_we    = r.we;
      per_add   = r.addr;
      per_wdata = r.wdata;
      per_be    = r.be;
      per_id    = r.id;
      @(negedge clk_i);
      while (!per_gnt)
      begin
         @(negedge clk_i);
      end
      check_flag(ar_valid, ~r.we, "axi_ar_valid_o at grant");
      check_flag(aw_valid, r.we, "axi_aw_valid_o at grant");
      check_flag(w_valid, r.we, "axi_w_valid_o at grant");
      pend_row[idx]   = r;
      pend_valid[idx] = 1'b1;
      @(posedge clk_i);
      #2;
      per_req = 1'b0;
   endtask

   // busy is high while anything is outstanding and low in the cycle after the last response
   task automatic drain();
      @(negedge clk_i);
      // Sample once the response monitor has run
      #1;
      while (pending_count() != 0)
      begin
         check_flag(busy, 1'b1, "busy_o with transactions outstanding");
         @(negedge clk_i);
         #1;
      end
      @(negedge clk_i);
      check_flag(busy, 1'b0, "busy_o after the last response");
      @(posedge clk_i);
      #2;
   endtask

   // Each response must match one outstanding request
   always @(negedge clk_i)
   begin
      if (rst_ni && per_r_valid)
      begin
         mon_idx = first_set(per_r_id);
         if (mon_idx >= N_ID || !pend_valid[mon_idx])
         begin
            abort_run("A response arrived for a requester with nothing outstanding");
         end
         check_id(per_r_id, pend_row[mon_idx].id, "per_slave_r_id_o");
         check_flag(per_r_opc, pend_row[mon_idx].exp_opc, "per_slave_r_opc_o");
         if (!pend_row[mon_idx].we && !pend_row[mon_idx].exp_opc)
         begin
            check_data(per_r_rdata, pend_row[mon_idx].exp_rdata, "per_slave_r_rdata_o");
         end
         pend_valid[mon_idx] = 1'b0;
         if (r_valid && b_valid)
         begin
            coincide_cnt = coincide_cnt + 1;
         end
      end
   end

   always @(posedge clk_i)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > timeout_limit)
      begin
         abort_run($sformatf("Timeout: the table did not finish within %0d cycles",
                             timeout_limit));
      end
   end

   // ************************************************************
   // Main sequence
   // ************************************************************
   initial
   begin
      void'($urandom(32353));
      rst_ni    = 1'b1;
      per_req   = 1'b0;
      per_we    = 1'b0;
      per_add   = '0;
      per_wdata = '0;
      per_be    = '0;
      per_id    = '0;
      for (int unsigned i = 0; i < N_ID; i++)
      begin
         pend_valid[i] = 1'b0;
      end
      for (int unsigned w = 0; w < 128; w++)
      begin
         golden[w] = fill_word(w * 4);
      end
      // Full words into both lanes and reads of them and of untouched words
      add_row(1, 1, 5'b00001, 32'h010, 32'h1111_2222, 4'hF);
      add_row(1, 1, 5'b00010, 32'h014, 32'h3333_4444, 4'hF);
      add_row(0, 1, 5'b00100, 32'h010, 32'h0, 4'hF);
      add_row(0, 1, 5'b01000, 32'h014, 32'h0, 4'hF);
      add_row(1, 1, 5'b10000, 32'h028, 32'hDEAD_BEEF, 4'hF);
      add_row(0, 1, 5'b00001, 32'h028, 32'h0, 4'hF);
      add_row(0, 1, 5'b00010, 32'h02C, 32'h0, 4'hF);
      add_row(0, 1, 5'b00100, 32'h020, 32'h0, 4'hF);
      // Partial byte enables merge into the existing word
      add_row(1, 1, 5'b01000, 32'h010, 32'hAABB_CCDD, 4'b0101);
      add_row(0, 1, 5'b10000, 32'h010, 32'h0, 4'hF);
      add_row(1, 1, 5'b00001, 32'h014, 32'h5566_7788, 4'b1000);
      add_row(0, 1, 5'b00010, 32'h014, 32'h0, 4'hF);
      add_row(1, 1, 5'b00100, 32'h034, 32'h0102_0304, 4'b0110);
      add_row(0, 1, 5'b01000, 32'h034, 32'h0, 4'hF);
      // Error window reads and writes
      add_row(0, 1, 5'b10000, 32'h100, 32'h0, 4'hF);
      add_row(1, 1, 5'b00001, 32'h104, 32'hFFFF_FFFF, 4'hF);
      add_row(0, 1, 5'b00010, 32'h1F8, 32'h0, 4'hF);
      add_row(1, 1, 5'b00100, 32'h1FC, 32'h5A5A_5A5A, 4'b0011);
      // Mixed traffic in flight with one request per ID per batch
      add_row(1, 0, 5'b00001, 32'h040, 32'h0BAD_F00D, 4'hF);
      add_row(0, 0, 5'b00010, 32'h048, 32'h0, 4'hF);
      add_row(1, 0, 5'b00100, 32'h04C, 32'h1234_5678, 4'hF);
      add_row(0, 0, 5'b01000, 32'h010, 32'h0, 4'hF);
      add_row(1, 1, 5'b10000, 32'h100, 32'h0000_0001, 4'hF);
      add_row(0, 0, 5'b10000, 32'h040, 32'h0, 4'hF);
      add_row(1, 0, 5'b01000, 32'h048, 32'hCAFE_0001, 4'b1100);
      add_row(0, 0, 5'b00100, 32'h04C, 32'h0, 4'hF);
      add_row(1, 0, 5'b00010, 32'h018, 32'h7777_8888, 4'hF);
      add_row(0, 1, 5'b00001, 32'h018, 32'h0, 4'hF);
      add_row(0, 1, 5'b00010, 32'h048, 32'h0, 4'hF);
      timeout_limit = row_q.size() * CYCLES_PER_ROW;
      // Reset edge at 1 ns so the slave model clears its outputs
      #1;
      rst_ni = 1'b0;
      repeat (RESET_CYCLES - 1) @(posedge clk_i);
      @(negedge clk_i);
      check_flag(per_gnt, 1'b0, "per_slave_gnt_o in reset");
      check_flag(aw_valid, 1'b0, "axi_aw_valid_o in reset");
      check_flag(w_valid, 1'b0, "axi_w_valid_o in reset");
      check_flag(ar_valid, 1'b0, "axi_ar_valid_o in reset");
      check_flag(per_r_valid, 1'b0, "per_slave_r_valid_o in reset");
      check_flag(busy, 1'b0, "busy_o in reset");
      @(posedge clk_i);
      #2;
      rst_ni = 1'b1;
      foreach (row_q[k])
      begin
         issue(row_q[k]);
         if (row_q[k].wait_rsp)
         begin
            drain();
         end
      end
      $display("R and B beats coincided in %0d response cycles", coincide_cnt);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/per_pkg.sv
common/axi_pkg.sv
common/per2axi_trans_if.sv
source/per2axi_req_channel.sv
source/per2axi_res_channel.sv
source/per2axi_busy_unit.sv
source/per2axi.sv
sim/axi_mem_model.sv
sim/tb_per2axi.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_per2axi
FILELIST  = all.f

.PHONY: sim clean

# Build and run, a failing run ends in $fatal and a nonzero exit status
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
